/* ara_cfg_pkg.sv */
// Architecture sizes of the vector coprocessor and the widths and types derived from them
package ara_cfg_pkg;

  // Number of parallel lanes
  localparam int unsigned NrLanes  = 4;
  // Width of one element in bits
  localparam int unsigned ElenBits = 32;
  // Architectural vector registers
  localparam int unsigned NrVRegs  = 8;
  // Elements per vector register
  localparam int unsigned MaxVl    = 8;
  // Largest number of lane beats per instruction
  localparam int unsigned MaxBeats = MaxVl / NrLanes;

  // Derived widths
  localparam int unsigned VlWidth      = $clog2(MaxVl + 1);
  localparam int unsigned VRegIdxWidth = $clog2(NrVRegs);
  localparam int unsigned BeatIdxWidth = (MaxBeats > 1) ? $clog2(MaxBeats) : 1;
  localparam int unsigned LaneIdxWidth = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  // One vector element
  typedef logic [ElenBits-1:0] elen_t;

  // Vector length, 0 up to MaxVl inclusive
  typedef logic [VlWidth-1:0] vl_t;

  // Vector register number
  typedef logic [VRegIdxWidth-1:0] vreg_idx_t;

  // Beat number within one instruction
  typedef logic [BeatIdxWidth-1:0] beat_idx_t;

endpackage

/* ara_isa_pkg.sv */
// Opcodes, instruction word layouts, decoded request and lane beat formats
package ara_isa_pkg;

  localparam int unsigned OpcodeBits   = 5;
  localparam int unsigned RegFieldBits = 5;

  typedef enum logic [OpcodeBits-1:0] {
    VSETVL = 5'd0,
    VMV_VX = 5'd1,
    VID    = 5'd2,
    VADD   = 5'd3,
    VSUB   = 5'd4,
    VAND   = 5'd5,
    VXOR   = 5'd6,
    VMUL   = 5'd7,
    VMV_XS = 5'd8
  } ara_op_e;

  // Vector-vector layout
  typedef struct packed {
    logic [31-OpcodeBits-3*RegFieldBits:0] rsvd;
    logic [RegFieldBits-1:0]               vs2;
    logic [RegFieldBits-1:0]               vs1;
    logic [RegFieldBits-1:0]               vd;
    logic [OpcodeBits-1:0]                 opcode;
  } ara_vv_insn_t;

  // Scalar layout, vreg is vd for writes and vs2 for readback
  typedef struct packed {
    logic [31-OpcodeBits-RegFieldBits:0] rsvd;
    logic [RegFieldBits-1:0]             vreg;
    logic [OpcodeBits-1:0]               opcode;
  } ara_sc_insn_t;

  typedef union packed {
    ara_vv_insn_t vv;
    ara_sc_insn_t sc;
  } ara_insn_u;

  typedef struct packed {
    ara_op_e                op;
    ara_cfg_pkg::vreg_idx_t vd;
    ara_cfg_pkg::vreg_idx_t vs1;
    ara_cfg_pkg::vreg_idx_t vs2;
    ara_cfg_pkg::elen_t     scalar;
  } ara_req_t;

  typedef struct packed {
    ara_op_e                op;
    ara_cfg_pkg::vreg_idx_t vd;
    ara_cfg_pkg::vreg_idx_t vs1;
    ara_cfg_pkg::vreg_idx_t vs2;
    ara_cfg_pkg::elen_t     scalar;
    ara_cfg_pkg::beat_idx_t beat;
    ara_cfg_pkg::vl_t       vl;
  } lane_beat_t;

endpackage

/* ara_intf.sv */
// Dispatcher to sequencer and sequencer to lanes interfaces
`timescale 1ns/1ps

// Request handshake towards the sequencer and its ordered result pulses
interface disp_seq_if;

  ara_isa_pkg::ara_req_t req;
  logic                  req_valid;
  logic                  req_ready;
  ara_cfg_pkg::elen_t    result;
  logic                  result_valid;
  logic                  result_error;

  modport dispatcher (
    output req,
    output req_valid,
    input  req_ready,
    input  result,
    input  result_valid,
    input  result_error
  );

  modport sequencer (
    input  req,
    input  req_valid,
    output req_ready,
    output result,
    output result_valid,
    output result_error
  );

endinterface

// Beat broadcast to all lanes, lanes never stall
interface seq_lane_if;

  ara_isa_pkg::lane_beat_t                              beat;
  logic                                                 beat_valid;
  // One readback slot per lane
  ara_cfg_pkg::elen_t [ara_cfg_pkg::NrLanes-1:0]        rd_data;
  logic               [ara_cfg_pkg::NrLanes-1:0]        rd_valid;

  modport sequencer (
    output beat,
    output beat_valid,
    input  rd_data,
    input  rd_valid
  );

  modport lane (
    input  beat,
    input  beat_valid,
    output rd_data,
    output rd_valid
  );

endinterface

/* lane_alu.sv */
// Element-wise arithmetic and logic unit of one lane
`timescale 1ns/1ps

module lane_alu (
  input  ara_isa_pkg::ara_op_e op_i,
  input  ara_cfg_pkg::elen_t   a_i,
  input  ara_cfg_pkg::elen_t   b_i,
  input  ara_cfg_pkg::elen_t   scalar_i,
  input  ara_cfg_pkg::elen_t   elem_idx_i,
  output ara_cfg_pkg::elen_t   res_o
);

  // a_i comes from vs1 and b_i from vs2
  always_comb begin
    case (op_i)
      ara_isa_pkg::VADD:   res_o = a_i + b_i;
      ara_isa_pkg::VSUB:   res_o = a_i - b_i;
      ara_isa_pkg::VAND:   res_o = a_i & b_i;
      ara_isa_pkg::VXOR:   res_o = a_i ^ b_i;
      // Low half of the product
      ara_isa_pkg::VMUL:   res_o = a_i * b_i;
      ara_isa_pkg::VMV_VX: res_o = scalar_i;
      ara_isa_pkg::VID:    res_o = elem_idx_i;
      default:             res_o = '0;
    endcase
  end

endmodule

/* vector_lane.sv */
// One lane with its register file slice, ALU write path and readback register
`timescale 1ns/1ps

module vector_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  seq_lane_if.lane    seq
);

  ara_cfg_pkg::elen_t vrf_q [ara_cfg_pkg::NrVRegs][ara_cfg_pkg::MaxBeats];
  ara_cfg_pkg::elen_t elem_idx;
  ara_cfg_pkg::elen_t alu_res;
  ara_cfg_pkg::elen_t rd_data_q;
  logic               rd_valid_q;
  logic               write_en;
  logic               rd_hit;

  // Elements are interleaved across lanes
  assign elem_idx = ara_cfg_pkg::elen_t'(seq.beat.beat) * ara_cfg_pkg::NrLanes + LaneId;

  assign write_en = seq.beat_valid &&
                    seq.beat.op != ara_isa_pkg::VMV_XS &&
                    seq.beat.op != ara_isa_pkg::VSETVL &&
                    elem_idx < ara_cfg_pkg::elen_t'(seq.beat.vl);

  assign rd_hit = seq.beat_valid && seq.beat.op == ara_isa_pkg::VMV_XS &&
                  seq.beat.scalar[ara_cfg_pkg::LaneIdxWidth-1:0] ==
                  ara_cfg_pkg::LaneIdxWidth'(LaneId);

  lane_alu i_lane_alu (
    .op_i       (seq.beat.op                          ),
    .a_i        (vrf_q[seq.beat.vs1][seq.beat.beat]   ),
    .b_i        (vrf_q[seq.beat.vs2][seq.beat.beat]   ),
    .scalar_i   (seq.beat.scalar                      ),
    .elem_idx_i (elem_idx                             ),
    .res_o      (alu_res                              )
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < ara_cfg_pkg::NrVRegs; r++) begin
        for (int b = 0; b < ara_cfg_pkg::MaxBeats; b++) begin
          vrf_q[r][b] <= '0;
        end
      end
    end else if (write_en) begin
      vrf_q[seq.beat.vd][seq.beat.beat] <= alu_res;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_hit;
    end
  end

  // Row of the element is the index above the lane bits
  always_ff @(posedge clk_i) begin
    if (rd_hit) begin
      rd_data_q <= vrf_q[seq.beat.vs2]
                        [seq.beat.scalar[ara_cfg_pkg::LaneIdxWidth +: ara_cfg_pkg::BeatIdxWidth]];
    end
  end

  assign seq.rd_data[LaneId]  = rd_data_q;
  assign seq.rd_valid[LaneId] = rd_valid_q;

endmodule

/* ara_sequencer.sv */
// Vector length register and beat sequencer feeding the lanes
`timescale 1ns/1ps

module ara_sequencer (
  input  logic             clk_i,
  input  logic             rst_n_i,
  disp_seq_if.sequencer    disp,
  seq_lane_if.sequencer    lanes
);

  logic                                   busy_q;
  logic                                   accept;
  ara_isa_pkg::lane_beat_t                beat_q;
  ara_cfg_pkg::beat_idx_t                 last_beat_q;
  ara_cfg_pkg::beat_idx_t                 last_beat;
  ara_cfg_pkg::vl_t                       vl_q;
  ara_cfg_pkg::vl_t                       vl_capped;
  logic                                   result_valid_q;
  ara_cfg_pkg::elen_t                     result_q;
  // Readback bookkeeping for VMV_XS
  logic                                   xs_pend_q;
  logic                                   xs_oob_q;
  logic [ara_cfg_pkg::LaneIdxWidth-1:0]   xs_lane_q;

  assign disp.req_ready = !busy_q;
  assign accept         = disp.req_valid && !busy_q;

  always_comb begin
    if (disp.req.scalar > ara_cfg_pkg::MaxVl) begin
      vl_capped = ara_cfg_pkg::vl_t'(ara_cfg_pkg::MaxVl);
    end else begin
      vl_capped = ara_cfg_pkg::vl_t'(disp.req.scalar);
    end
  end

  // ceil(vl / NrLanes) - 1, only used when vl is nonzero
  assign last_beat = ara_cfg_pkg::beat_idx_t'((vl_q - 1'b1) / ara_cfg_pkg::NrLanes);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q         <= 1'b0;
      vl_q           <= ara_cfg_pkg::vl_t'(ara_cfg_pkg::MaxVl);
      result_valid_q <= 1'b0;
      xs_pend_q      <= 1'b0;
    end else begin
      result_valid_q <= 1'b0;
      xs_pend_q      <= 1'b0;
      if (accept) begin
        if (disp.req.op == ara_isa_pkg::VSETVL) begin
          vl_q           <= vl_capped;
          result_valid_q <= 1'b1;
        end else if (disp.req.op == ara_isa_pkg::VMV_XS || vl_q != '0) begin
          busy_q <= 1'b1;
        end else begin
          // Empty vector, nothing to issue
          result_valid_q <= 1'b1;
        end
      end else if (busy_q && beat_q.beat == last_beat_q) begin
        busy_q <= 1'b0;
        if (beat_q.op == ara_isa_pkg::VMV_XS) begin
          xs_pend_q <= 1'b1;
        end else begin
          result_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      beat_q.op     <= disp.req.op;
      beat_q.vd     <= disp.req.vd;
      beat_q.vs1    <= disp.req.vs1;
      beat_q.vs2    <= disp.req.vs2;
      beat_q.scalar <= disp.req.scalar;
      beat_q.beat   <= '0;
      beat_q.vl     <= vl_q;
      last_beat_q   <= (disp.req.op == ara_isa_pkg::VMV_XS) ? '0 : last_beat;
      result_q      <= (disp.req.op == ara_isa_pkg::VSETVL) ?
                       ara_cfg_pkg::elen_t'(vl_capped) : '0;
      xs_lane_q     <= disp.req.scalar[ara_cfg_pkg::LaneIdxWidth-1:0];
      xs_oob_q      <= disp.req.scalar >= ara_cfg_pkg::MaxVl;
    end else if (busy_q) begin
      beat_q.beat <= beat_q.beat + 1'b1;
    end
  end

  assign lanes.beat       = beat_q;
  assign lanes.beat_valid = busy_q;

  // Readback element arrives the cycle after its beat
  assign disp.result_valid = result_valid_q | (xs_pend_q & lanes.rd_valid[xs_lane_q]);
  assign disp.result       = !xs_pend_q ? result_q :
                             xs_oob_q   ? '0       : lanes.rd_data[xs_lane_q];
  // No fault sources past the decoder
  assign disp.result_error = 1'b0;

endmodule

/* ara_dispatcher.sv */
// Host instruction decoder and checker with the response ordering FSM
`timescale 1ns/1ps

module ara_dispatcher (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [31:0]           acc_req_i,
  input  ara_cfg_pkg::elen_t    acc_scalar_i,
  input  logic                  acc_req_valid_i,
  output logic                  acc_req_ready_o,
  output ara_cfg_pkg::elen_t    acc_resp_data_o,
  output logic                  acc_resp_error_o,
  output logic                  acc_resp_valid_o,
  input  logic                  acc_resp_ready_i,
  disp_seq_if.dispatcher        seq
);

  enum logic [1:0] {IDLE, FORWARD, WAIT_RESULT, RESPOND} state_q, state_d;

  ara_isa_pkg::ara_insn_u insn;
  ara_isa_pkg::ara_req_t  dec_req;
  ara_isa_pkg::ara_req_t  req_q;
  logic                   legal;
  ara_cfg_pkg::elen_t     resp_data_q;
  logic                   resp_error_q;

  function automatic logic reg_ok(input logic [ara_isa_pkg::RegFieldBits-1:0] field);
    return field < ara_cfg_pkg::NrVRegs;
  endfunction

  assign insn = acc_req_i;

  // Pick the instruction view from the opcode
  always_comb begin
    dec_req        = '0;
    dec_req.scalar = acc_scalar_i;
    legal          = 1'b1;
    case (insn.vv.opcode)
      ara_isa_pkg::VSETVL: begin
        dec_req.op = ara_isa_pkg::VSETVL;
      end
      ara_isa_pkg::VMV_VX, ara_isa_pkg::VID: begin
        dec_req.op = ara_isa_pkg::ara_op_e'(insn.sc.opcode);
        dec_req.vd = ara_cfg_pkg::vreg_idx_t'(insn.sc.vreg);
        legal      = reg_ok(insn.sc.vreg);
      end
      ara_isa_pkg::VMV_XS: begin
        dec_req.op  = ara_isa_pkg::VMV_XS;
        dec_req.vs2 = ara_cfg_pkg::vreg_idx_t'(insn.sc.vreg);
        legal       = reg_ok(insn.sc.vreg);
      end
      ara_isa_pkg::VADD, ara_isa_pkg::VSUB, ara_isa_pkg::VAND,
      ara_isa_pkg::VXOR, ara_isa_pkg::VMUL: begin
        dec_req.op  = ara_isa_pkg::ara_op_e'(insn.vv.opcode);
        dec_req.vd  = ara_cfg_pkg::vreg_idx_t'(insn.vv.vd);
        dec_req.vs1 = ara_cfg_pkg::vreg_idx_t'(insn.vv.vs1);
        dec_req.vs2 = ara_cfg_pkg::vreg_idx_t'(insn.vv.vs2);
        legal       = reg_ok(insn.vv.vd) && reg_ok(insn.vv.vs1) && reg_ok(insn.vv.vs2);
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  // One instruction in flight, illegal ones skip the sequencer
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:        if (acc_req_valid_i) state_d = legal ? FORWARD : RESPOND;
      FORWARD:     if (seq.req_ready) state_d = WAIT_RESULT;
      WAIT_RESULT: if (seq.result_valid) state_d = RESPOND;
      RESPOND:     if (acc_resp_ready_i) state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && acc_req_valid_i) begin
      req_q        <= dec_req;
      resp_data_q  <= '0;
      resp_error_q <= !legal;
    end else if (state_q == WAIT_RESULT && seq.result_valid) begin
      resp_data_q  <= seq.result;
      resp_error_q <= seq.result_error;
    end
  end

  assign seq.req           = req_q;
  assign seq.req_valid     = (state_q == FORWARD);
  assign acc_req_ready_o   = (state_q == IDLE);
  assign acc_resp_valid_o  = (state_q == RESPOND);
  assign acc_resp_data_o   = resp_data_q;
  assign acc_resp_error_o  = resp_error_q;

endmodule

/* ara.sv */
// Vector coprocessor top level with dispatcher, sequencer and lane array
`timescale 1ns/1ps

module ara (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Host request channel
  input  logic [31:0]        acc_req_i,
  input  ara_cfg_pkg::elen_t acc_scalar_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  // Host response channel
  output ara_cfg_pkg::elen_t acc_resp_data_o,
  output logic               acc_resp_error_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  disp_seq_if disp_seq ();
  seq_lane_if seq_lane ();

  ara_dispatcher i_dispatcher (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_scalar_i     (acc_scalar_i    ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_data_o  (acc_resp_data_o ),
    .acc_resp_error_o (acc_resp_error_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .seq              (disp_seq        )
  );

  ara_sequencer i_sequencer (
    .clk_i   (clk_i   ),
    .rst_n_i (rst_n_i ),
    .disp    (disp_seq),
    .lanes   (seq_lane)
  );

  // All lanes see the same beat and answer in their own readback slot
  for (genvar lane = 0; lane < ara_cfg_pkg::NrLanes; lane++) begin : gen_lanes
    vector_lane #(
      .LaneId (lane)
    ) i_lane (
      .clk_i   (clk_i   ),
      .rst_n_i (rst_n_i ),
      .seq     (seq_lane)
    );
  end

endmodule

/* ara_checker.sv */
// Response monitor comparing host responses with queued expectations, checking request ready
`timescale 1ns/1ps

module ara_checker (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               req_valid_i,
  input logic               req_ready_i,
  input ara_cfg_pkg::elen_t resp_data_i,
  input logic               resp_error_i,
  input logic               resp_valid_i,
  input logic               resp_ready_i
);

  // Expectations in request order
  string              exp_name_q[$];
  ara_cfg_pkg::elen_t exp_data_q[$];
  logic               exp_error_q[$];

  // Request accepted and its response not yet transferred
  logic outstanding = 1'b0;

  int pass_count = 0;
  int fail_count = 0;

  task automatic expect_resp(input string name, input ara_cfg_pkg::elen_t data,
                             input logic error);
    exp_name_q.push_back(name);
    exp_data_q.push_back(data);
    exp_error_q.push_back(error);
  endtask

  always @(posedge clk_i) begin : compare
    string              name;
    ara_cfg_pkg::elen_t data;
    logic               error;
    logic               ok;
    if (!rst_n_i) begin
      outstanding = 1'b0;
    end
    // Ready must stay low from acceptance until the response transfers
    if (rst_n_i && outstanding && req_ready_i) begin
      $display("ERROR: DUT was ready for a new request while a response was outstanding");
      fail_count++;
    end
    if (rst_n_i && req_valid_i && req_ready_i) begin
      outstanding = 1'b1;
    end
    if (rst_n_i && resp_valid_i && resp_ready_i) begin
      outstanding = 1'b0;
      if (exp_name_q.size() == 0) begin
        $display("ERROR: unexpected response with data 0x%08h, no request was pending",
                 resp_data_i);
        fail_count++;
      end else begin
        name  = exp_name_q.pop_front();
        data  = exp_data_q.pop_front();
        error = exp_error_q.pop_front();
        ok    = 1'b1;
        if (resp_data_i !== data) begin
          $display("MISMATCH %s: data expected 0x%08h actual 0x%08h", name, data, resp_data_i);
          ok = 1'b0;
        end
        if (resp_error_i !== error) begin
          $display("MISMATCH %s: error flag expected %0b actual %0b", name, error, resp_error_i);
          ok = 1'b0;
        end
        if (ok) begin
          pass_count++;
          $display("PASS %s: data 0x%08h error %0b", name, resp_data_i, resp_error_i);
        end else begin
          fail_count++;
        end
      end
    end
  end

  // Responses still pending at the end
  task automatic report(output int errors);
    if (exp_name_q.size() != 0) begin
      $display("ERROR: %0d expected responses never arrived, first one is %s",
               exp_name_q.size(), exp_name_q[0]);
      fail_count += exp_name_q.size();
    end
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    errors = fail_count;
  endtask

endmodule

/* tb_ara.sv */
// Testbench top with clock, reset, stimulus table, drive loop and watchdog
`timescale 1ns/1ps

module tb_ara;

  logic               clk;
  logic               rst_n;
  logic [31:0]        acc_req;
  ara_cfg_pkg::elen_t acc_scalar;
  logic               acc_req_valid;
  logic               acc_req_ready;
  ara_cfg_pkg::elen_t acc_resp_data;
  logic               acc_resp_error;
  logic               acc_resp_valid;
  logic               acc_resp_ready;

  // Stimulus table with one entry per host instruction
  string              name_q[$];
  logic [31:0]        word_q[$];
  ara_cfg_pkg::elen_t scalar_q[$];
  ara_cfg_pkg::elen_t exp_data_q[$];
  logic               exp_error_q[$];

  int seed = 7483;
  int watchdog_cycles = 0;
  int errors;

  ara DUT (
    .clk_i            (clk           ),
    .rst_n_i          (rst_n         ),
    .acc_req_i        (acc_req       ),
    .acc_scalar_i     (acc_scalar    ),
    .acc_req_valid_i  (acc_req_valid ),
    .acc_req_ready_o  (acc_req_ready ),
    .acc_resp_data_o  (acc_resp_data ),
    .acc_resp_error_o (acc_resp_error),
    .acc_resp_valid_o (acc_resp_valid),
    .acc_resp_ready_i (acc_resp_ready)
  );

  ara_checker i_checker (
    .clk_i        (clk           ),
    .rst_n_i      (rst_n         ),
    .req_valid_i  (acc_req_valid ),
    .req_ready_i  (acc_req_ready ),
    .resp_data_i  (acc_resp_data ),
    .resp_error_i (acc_resp_error),
    .resp_valid_i (acc_resp_valid),
    .resp_ready_i (acc_resp_ready)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] vv_word(input logic [4:0] opcode, input int vd,
                                          input int vs1, input int vs2);
    ara_isa_pkg::ara_insn_u insn;
    insn           = '0;
    insn.vv.opcode = opcode;
    insn.vv.vd     = 5'(vd);
    insn.vv.vs1    = 5'(vs1);
    insn.vv.vs2    = 5'(vs2);
    return insn;
  endfunction

  function automatic logic [31:0] sc_word(input logic [4:0] opcode, input int vreg);
    ara_isa_pkg::ara_insn_u insn;
    insn           = '0;
    insn.sc.opcode = opcode;
    insn.sc.vreg   = 5'(vreg);
    return insn;
  endfunction

  task automatic add_entry(input string name, input logic [31:0] word,
                           input ara_cfg_pkg::elen_t scalar, input ara_cfg_pkg::elen_t data,
                           input logic error);
    name_q.push_back(name);
    word_q.push_back(word);
    scalar_q.push_back(scalar);
    exp_data_q.push_back(data);
    exp_error_q.push_back(error);
  endtask

  // Element readback where the scalar is the element index
  task automatic add_readback(input string tag, input int vreg, input int idx,
                              input ara_cfg_pkg::elen_t data);
    add_entry($sformatf("%s_rd%0d", tag, idx), sc_word(ara_isa_pkg::VMV_XS, vreg), idx, data,
              1'b0);
  endtask

  task automatic build_table();
    // Length is capped at the register size
    add_entry("vsetvl_0", sc_word(ara_isa_pkg::VSETVL, 0), 0, 0, 1'b0);
    add_entry("vsetvl_5", sc_word(ara_isa_pkg::VSETVL, 0), 5, 5, 1'b0);
    add_entry("vsetvl_8", sc_word(ara_isa_pkg::VSETVL, 0), 8, 8, 1'b0);
    add_entry("vsetvl_100", sc_word(ara_isa_pkg::VSETVL, 0), 100, 8, 1'b0);
    add_entry("vid_v1", sc_word(ara_isa_pkg::VID, 1), 0, 0, 1'b0);
    for (int i = 0; i < 8; i++) begin
      add_readback("vid", 1, i, i);
    end
    add_readback("vid_oob", 1, 9, 0);
    add_entry("vmv_v2_10", sc_word(ara_isa_pkg::VMV_VX, 2), 10, 0, 1'b0);
    add_readback("vmv", 2, 5, 10);
    // v3 = v1 op v2 with v1 holding the index and v2 holding 10
    add_entry("vadd", vv_word(ara_isa_pkg::VADD, 3, 1, 2), 0, 0, 1'b0);
    add_readback("vadd", 3, 2, 2 + 10);
    add_readback("vadd", 3, 7, 7 + 10);
    add_entry("vsub", vv_word(ara_isa_pkg::VSUB, 3, 1, 2), 0, 0, 1'b0);
    add_readback("vsub", 3, 2, ara_cfg_pkg::elen_t'(2 - 10));
    add_readback("vsub", 3, 7, ara_cfg_pkg::elen_t'(7 - 10));
    add_entry("vand", vv_word(ara_isa_pkg::VAND, 3, 1, 2), 0, 0, 1'b0);
    add_readback("vand", 3, 2, 2 & 10);
    add_readback("vand", 3, 7, 7 & 10);
    add_entry("vxor", vv_word(ara_isa_pkg::VXOR, 3, 1, 2), 0, 0, 1'b0);
    add_readback("vxor", 3, 2, 2 ^ 10);
    add_readback("vxor", 3, 7, 7 ^ 10);
    add_entry("vmul", vv_word(ara_isa_pkg::VMUL, 3, 1, 2), 0, 0, 1'b0);
    add_readback("vmul", 3, 2, 2 * 10);
    add_readback("vmul", 3, 7, 7 * 10);
    // Tail beyond length 5 keeps the indices from VID
    add_entry("vsetvl_tail", sc_word(ara_isa_pkg::VSETVL, 0), 5, 5, 1'b0);
    add_entry("vmv_v1_7", sc_word(ara_isa_pkg::VMV_VX, 1), 7, 0, 1'b0);
    add_readback("tail", 1, 4, 7);
    add_readback("tail", 1, 5, 5);
    add_readback("tail", 1, 6, 6);
    // Illegal words whose truncated register field would hit v1
    add_entry("bad_opcode", sc_word(5'd20, 1), 99, 0, 1'b1);
    add_entry("bad_vmv_reg", sc_word(ara_isa_pkg::VMV_VX, 9), 55, 0, 1'b1);
    add_readback("after_bad", 1, 0, 7);
    add_entry("bad_vadd_reg", vv_word(ara_isa_pkg::VADD, 9, 1, 2), 0, 0, 1'b1);
    add_readback("after_bad", 1, 1, 7);
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    acc_req        = '0;
    acc_scalar     = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b1;
    build_table();
    watchdog_cycles = name_q.size() * 40;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < name_q.size(); i++) begin
      int hold;
      @(negedge clk);
      acc_req       = word_q[i];
      acc_scalar    = scalar_q[i];
      acc_req_valid = 1'b1;
      while (!acc_req_ready) @(negedge clk);
      // Transfer happens at the coming rising edge
      i_checker.expect_resp(name_q[i], exp_data_q[i], exp_error_q[i]);
      hold = $unsigned($random(seed)) % 6;
      if (hold > 3) hold = 0;
      @(negedge clk);
      acc_req_valid  = 1'b0;
      acc_resp_ready = (hold == 0);
      // Back-pressure holds the offered response for a few cycles
      while (!acc_resp_valid) @(negedge clk);
      repeat (hold) @(negedge clk);
      acc_resp_ready = 1'b1;
    end

    repeat (2) @(negedge clk);
    i_checker.report(errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles + 3) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped answering", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* src.f */
ara_cfg_pkg.sv
ara_isa_pkg.sv
ara_intf.sv
lane_alu.sv
vector_lane.sv
ara_sequencer.sv
ara_dispatcher.sv
ara.sv
ara_checker.sv
tb_ara.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ara -f src.f -o sim_ara
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ara > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation run exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

exit 0
